//--- build.f
rtl/sdram_pkg.sv
rtl/sdram_power_up.sv
rtl/sdram_access_seq.sv
rtl/sdram_pin_stage.sv
rtl/sdram_interface.sv
testbench/sdram_checker.sv
testbench/sdram_monitor.sv
testbench/tb_sdram_interface.sv

//--- rtl/sdram_access_seq.sv
// Read and write access sequencer, wakes the SDRAM for one word and parks it again
module sdram_access_seq (
    input  logic                  CLK_48MHZ,
    input  logic                  RESET,
    input  logic                  init_done,
    input  sdram_pkg::host_req_t  req,
    output sdram_pkg::sdram_bus_t acc_bus,
    output logic                  capture,
    output logic                  busy
);

    logic                           accept;
    logic                           is_read;
    logic [sdram_pkg::STEP_W-1:0]   step;
    logic [sdram_pkg::STEP_W-1:0]   last_step;
    logic [sdram_pkg::ROW_W-1:0]    col_addr;
    sdram_pkg::host_req_t           req_q;
    sdram_pkg::sdram_bus_t          step_bus;

    // New command taken only while idle and initialized
    assign accept = init_done && !busy &&
                    (req.op == sdram_pkg::OP_READ || req.op == sdram_pkg::OP_WRITE);

    assign is_read   = (req_q.op == sdram_pkg::OP_READ);
    assign last_step = is_read ? sdram_pkg::READ_LAST_STEP : sdram_pkg::WRITE_LAST_STEP;

    //////////////////////////////////////////////////
    // Command order per step
    //////////////////////////////////////////////////
    always_comb begin
        col_addr                      = '0;
        col_addr[sdram_pkg::COL_W-1:0] = req_q.col;
        col_addr[sdram_pkg::AP_BIT]   = 1'b1;

        step_bus = sdram_pkg::BUS_PARKED;
        if (step == 4'd0) begin
            step_bus.cmd = sdram_pkg::CMD_SELFX;
        end else if (step < sdram_pkg::T_RC) begin
            step_bus.cmd = sdram_pkg::CMD_NOP;
        end else if (step == sdram_pkg::T_RC) begin
            // Open the row
            step_bus.cmd  = sdram_pkg::CMD_ACTV;
            step_bus.ba   = req_q.bank;
            step_bus.addr = req_q.row;
            step_bus.dqm  = 2'b00;
        end else if (step < sdram_pkg::T_RC + sdram_pkg::T_RAS) begin
            step_bus.cmd = sdram_pkg::CMD_NOP;
            step_bus.ba  = req_q.bank;
            step_bus.dqm = 2'b00;
        end else if (step == sdram_pkg::T_RC + sdram_pkg::T_RAS) begin
            // Column access, auto-precharge closes the row
            step_bus.ba   = req_q.bank;
            step_bus.addr = col_addr;
            step_bus.dqm  = 2'b00;
            if (is_read) begin
                step_bus.cmd = sdram_pkg::CMD_READA;
            end else begin
                step_bus.cmd    = sdram_pkg::CMD_WRITA;
                step_bus.dq_oe  = 1'b1;
                step_bus.dq_out = req_q.wdata;
            end
        end else if (step < last_step) begin
            // Mask goes up on the cycle before SELF
            step_bus.cmd = sdram_pkg::CMD_NOP;
            step_bus.dqm = (step == last_step - 4'd1) ? 2'b11 : 2'b00;
        end else if (step == last_step) begin
            step_bus.cmd = sdram_pkg::CMD_SELF;
        end
    end

    //////////////////////////////////////////////////
    // Step counter and busy
    //////////////////////////////////////////////////
    always_ff @(negedge CLK_48MHZ) begin
        if (!RESET) begin
            busy    <= 1'b0;
            step    <= '0;
            capture <= 1'b0;
        end else begin
            capture <= busy && is_read && (step == sdram_pkg::READ_CAPTURE_STEP);
            if (accept) begin
                busy <= 1'b1;
                step <= 4'd1;
            end else if (busy) begin
                // Busy clears as SELF reaches the pins
                if (step == last_step + 4'd1) begin
                    busy <= 1'b0;
                    step <= '0;
                end else begin
                    step <= step + 4'd1;
                end
            end
        end
    end

    // Request held for the whole access
    always_ff @(negedge CLK_48MHZ) begin
        if (accept) begin
            req_q <= req;
        end
        if (busy || accept) begin
            acc_bus <= step_bus;
        end else begin
            acc_bus <= sdram_pkg::BUS_PARKED;
        end
    end

endmodule

//--- rtl/sdram_interface.sv
// Top level of the single-word SDRAM controller, the board wrapper adds the DQ pad
module sdram_interface (
    input  logic                           CLK_48MHZ,
    input  logic                           RESET,
    input  logic [sdram_pkg::TS_W-1:0]     timestamp,
    input  sdram_pkg::host_req_t           req,
    input  logic [sdram_pkg::DATA_W-1:0]   dq_in,
    output logic                           sdram_clk,
    output logic                           cke,
    output logic                           cs_n,
    output logic                           ras_n,
    output logic                           cas_n,
    output logic                           we_n,
    output logic [sdram_pkg::BANK_W-1:0]   ba,
    output logic [sdram_pkg::ROW_W-1:0]    addr,
    output logic                           dqml,
    output logic                           dqmu,
    output logic [sdram_pkg::DATA_W-1:0]   dq_out,
    output logic                           dq_oe,
    output logic                           status,
    output logic [sdram_pkg::DATA_W-1:0]   data_read
);

    sdram_pkg::sdram_bus_t init_bus;
    sdram_pkg::sdram_bus_t acc_bus;
    logic                  init_done;
    logic                  clk_run;
    logic                  capture;
    logic                  busy;

    // Host must wait while low-level init or an access is running
    assign status = busy | ~init_done;

    sdram_power_up u_power_up (
        .CLK_48MHZ (CLK_48MHZ),
        .RESET     (RESET),
        .timestamp (timestamp),
        .init_bus  (init_bus),
        .clk_run   (clk_run),
        .init_done (init_done)
    );

    sdram_access_seq u_access_seq (
        .CLK_48MHZ (CLK_48MHZ),
        .RESET     (RESET),
        .init_done (init_done),
        .req       (req),
        .acc_bus   (acc_bus),
        .capture   (capture),
        .busy      (busy)
    );

    sdram_pin_stage u_pin_stage (
        .CLK_48MHZ (CLK_48MHZ),
        .RESET     (RESET),
        .init_done (init_done),
        .clk_run   (clk_run),
        .init_bus  (init_bus),
        .acc_bus   (acc_bus),
        .capture   (capture),
        .dq_in     (dq_in),
        .sdram_clk (sdram_clk),
        .cke       (cke),
        .cs_n      (cs_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .ba        (ba),
        .addr      (addr),
        .dqml      (dqml),
        .dqmu      (dqmu),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .data_read (data_read)
    );

endmodule

//--- rtl/sdram_pin_stage.sv
// Output register stage for all SDRAM pins, with clock gating and read data capture
module sdram_pin_stage (
    input  logic                           CLK_48MHZ,
    input  logic                           RESET,
    input  logic                           init_done,
    input  logic                           clk_run,
    input  sdram_pkg::sdram_bus_t          init_bus,
    input  sdram_pkg::sdram_bus_t          acc_bus,
    input  logic                           capture,
    input  logic [sdram_pkg::DATA_W-1:0]   dq_in,
    output logic                           sdram_clk,
    output logic                           cke,
    output logic                           cs_n,
    output logic                           ras_n,
    output logic                           cas_n,
    output logic                           we_n,
    output logic [sdram_pkg::BANK_W-1:0]   ba,
    output logic [sdram_pkg::ROW_W-1:0]    addr,
    output logic                           dqml,
    output logic                           dqmu,
    output logic [sdram_pkg::DATA_W-1:0]   dq_out,
    output logic                           dq_oe,
    output logic [sdram_pkg::DATA_W-1:0]   data_read
);

    sdram_pkg::sdram_bus_t sel_bus;
    sdram_pkg::sdram_bus_t pin_bus;
    logic                  clk_run_q;

    // Power-up sequencer owns the pins until init is done
    assign sel_bus = init_done ? acc_bus : init_bus;

    // Falling-edge update keeps pins stable at the SDRAM rising edge
    always_ff @(negedge CLK_48MHZ) begin
        if (!RESET) begin
            pin_bus   <= '0;
            clk_run_q <= 1'b0;
        end else begin
            pin_bus   <= sel_bus;
            clk_run_q <= clk_run;
        end
    end

    // Read data valid CAS latency after READA
    always_ff @(negedge CLK_48MHZ) begin
        if (capture) begin
            data_read <= dq_in;
        end
    end

    // Gate only changes while CLK_48MHZ is low
    assign sdram_clk = CLK_48MHZ & clk_run_q;

    assign cke    = pin_bus.cmd.cke;
    assign cs_n   = pin_bus.cmd.cs_n;
    assign ras_n  = pin_bus.cmd.ras_n;
    assign cas_n  = pin_bus.cmd.cas_n;
    assign we_n   = pin_bus.cmd.we_n;
    assign ba     = pin_bus.ba;
    assign addr   = pin_bus.addr;
    assign dqml   = pin_bus.dqm[0];
    assign dqmu   = pin_bus.dqm[1];
    assign dq_out = pin_bus.dq_out;
    assign dq_oe  = pin_bus.dq_oe;

endmodule

//--- rtl/sdram_pkg.sv
// Shared widths, timing, command encodings and pin bus structs for the SDRAM controller
package sdram_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int DATA_W = 16;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;
    localparam int TS_W   = 24;
    localparam int STEP_W = 4;

    // Timing in CLK_48MHZ cycles (20.8 ns each)
    localparam logic [STEP_W-1:0] T_RC  = 4'd4;
    localparam logic [STEP_W-1:0] T_RAS = 4'd3;
    localparam logic [STEP_W-1:0] T_RP  = 4'd2;

    // Must agree with the CAS field of MODE_REG
    localparam int CAS_LATENCY = 2;

    // Single-location write burst, CAS latency 2, burst length 1
    localparam logic [ROW_W-1:0]  MODE_REG  = 13'b0_0010_0010_0000;
    localparam logic [BANK_W-1:0] MODE_BANK = 2'd1;

    // A10 selects auto-precharge on column commands and all banks on PALL
    localparam int AP_BIT = 10;

    // Access step positions
    localparam logic [STEP_W-1:0] READ_CAPTURE_STEP = 4'd10;
    localparam logic [STEP_W-1:0] WRITE_LAST_STEP   = 4'd9;
    localparam logic [STEP_W-1:0] READ_LAST_STEP    = 4'd12;

    // Power-up step positions
    localparam logic [STEP_W-1:0] INIT_HOLD_STEP = T_RP + 4'd1;
    localparam logic [STEP_W-1:0] INIT_MRS_STEP  = INIT_HOLD_STEP + T_RC;
    localparam logic [STEP_W-1:0] INIT_SELF_STEP = INIT_MRS_STEP + 4'd2;
    localparam logic [STEP_W-1:0] INIT_DONE_STEP = INIT_SELF_STEP + 4'd1;

    // Power-up timestamp marks
    localparam logic [TS_W-1:0] TS_STABLE = 24'd2;
    localparam logic [TS_W-1:0] TS_INIT   = 24'd4;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } host_op_e;

    typedef struct packed {
        host_op_e          op;
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
        logic [DATA_W-1:0] wdata;
    } host_req_t;

    typedef struct packed {
        logic cke;
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } sdram_cmd_t;

    // Bit order cke, cs_n, ras_n, cas_n, we_n
    localparam sdram_cmd_t CMD_NOP     = 5'b10111;
    localparam sdram_cmd_t CMD_ACTV    = 5'b10011;
    localparam sdram_cmd_t CMD_READA   = 5'b10101;
    localparam sdram_cmd_t CMD_WRITA   = 5'b10100;
    localparam sdram_cmd_t CMD_PALL    = 5'b10010;
    localparam sdram_cmd_t CMD_MRS     = 5'b10000;
    localparam sdram_cmd_t CMD_SELF    = 5'b00001;
    localparam sdram_cmd_t CMD_SELFX   = 5'b10111;
    localparam sdram_cmd_t CMD_SR_HOLD = 5'b00111;

    typedef struct packed {
        sdram_cmd_t        cmd;
        logic [BANK_W-1:0] ba;
        logic [ROW_W-1:0]  addr;
        logic [1:0]        dqm;
        logic              dq_oe;
        logic [DATA_W-1:0] dq_out;
    } sdram_bus_t;

    // Device parked in self-refresh between accesses
    localparam sdram_bus_t BUS_PARKED = '{
        cmd:    CMD_SR_HOLD,
        ba:     '0,
        addr:   '0,
        dqm:    2'b11,
        dq_oe:  1'b0,
        dq_out: '0
    };

endpackage

//--- rtl/sdram_power_up.sv
// Power-up sequencer paced by the timestamp, drives the pins until the SDRAM is initialized
module sdram_power_up (
    input  logic                         CLK_48MHZ,
    input  logic                         RESET,
    input  logic [sdram_pkg::TS_W-1:0]   timestamp,
    output sdram_pkg::sdram_bus_t        init_bus,
    output logic                         clk_run,
    output logic                         init_done
);

    logic [sdram_pkg::STEP_W-1:0] step;
    logic [sdram_pkg::TS_W-1:0]   ts_target;
    sdram_pkg::sdram_bus_t        step_bus;

    //////////////////////////////////////////////////
    // Pin values for the current step
    //////////////////////////////////////////////////
    always_comb begin
        step_bus     = '0;
        step_bus.cmd = sdram_pkg::CMD_NOP;
        step_bus.dqm = 2'b11;
        case (step)
            4'd0: begin
                if (timestamp < sdram_pkg::TS_STABLE) begin
                    // Power still settling, everything low
                    step_bus = '0;
                end else if (timestamp >= sdram_pkg::TS_INIT) begin
                    // Precharge all banks
                    step_bus.cmd                      = sdram_pkg::CMD_PALL;
                    step_bus.addr[sdram_pkg::AP_BIT] = 1'b1;
                end
            end
            sdram_pkg::T_RP: begin
                step_bus.cmd = sdram_pkg::CMD_SELF;
            end
            sdram_pkg::INIT_HOLD_STEP: begin
                // Self-refresh runs for one timestamp step
                if (timestamp == ts_target) begin
                    step_bus.cmd = sdram_pkg::CMD_SELFX;
                end else begin
                    step_bus.cmd = sdram_pkg::CMD_SR_HOLD;
                end
            end
            sdram_pkg::INIT_MRS_STEP: begin
                step_bus.cmd  = sdram_pkg::CMD_MRS;
                step_bus.ba   = sdram_pkg::MODE_BANK;
                step_bus.addr = sdram_pkg::MODE_REG;
            end
            sdram_pkg::INIT_SELF_STEP: begin
                // Park in self-refresh
                step_bus.cmd = sdram_pkg::CMD_SELF;
            end
            sdram_pkg::INIT_DONE_STEP: begin
                step_bus = sdram_pkg::BUS_PARKED;
            end
            default: begin
                step_bus.cmd = sdram_pkg::CMD_NOP;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Step counter and done flag
    //////////////////////////////////////////////////
    always_ff @(negedge CLK_48MHZ) begin
        if (!RESET) begin
            step      <= '0;
            ts_target <= '0;
            clk_run   <= 1'b0;
            init_done <= 1'b0;
            init_bus  <= '0;
        end else begin
            init_bus <= step_bus;

            // SDRAM clock released once power is stable, then left running
            if (timestamp >= sdram_pkg::TS_STABLE) begin
                clk_run <= 1'b1;
            end

            // Self-refresh exit target, one timestamp past SELF entry
            if (step == sdram_pkg::T_RP) begin
                ts_target <= timestamp + sdram_pkg::TS_W'(1);
            end

            case (step)
                4'd0: begin
                    if (timestamp >= sdram_pkg::TS_INIT) begin
                        step <= step + 4'd1;
                    end
                end
                sdram_pkg::INIT_HOLD_STEP: begin
                    if (timestamp == ts_target) begin
                        step <= step + 4'd1;
                    end
                end
                sdram_pkg::INIT_DONE_STEP: begin
                    // One edge after SELF, so status falls with SELF on the pins
                    init_done <= 1'b1;
                end
                default: begin
                    step <= step + 4'd1;
                end
            endcase
        end
    end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sdram_interface -f build.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    exit 1
fi
exit 0

//--- testbench/sdram_checker.sv
// Concurrent pin assertions for the SDRAM controller, bound into the top level at elaboration
module sdram_checker (
    input logic CLK_48MHZ,
    input logic RESET,
    input logic sdram_clk,
    input logic cke,
    input logic cs_n,
    input logic ras_n,
    input logic cas_n,
    input logic we_n,
    input logic dq_oe,
    input logic status
);

    logic cke_seen;

    always_ff @(posedge CLK_48MHZ) begin
        if (!RESET) begin
            cke_seen <= 1'b0;
        end else if (cke) begin
            cke_seen <= 1'b1;
        end
    end

    // Data bus driven only together with a write command
    dq_oe_only_on_writa: assert property (@(posedge CLK_48MHZ) disable iff (!RESET)
        dq_oe |-> ({cke, cs_n, ras_n, cas_n, we_n} == sdram_pkg::CMD_WRITA))
        else $error("dq_oe high without WRITA on the pins");

    // Idle controller keeps the device in self-refresh
    idle_in_self_refresh: assert property (@(posedge CLK_48MHZ) disable iff (!RESET)
        !status |-> !cke)
        else $error("status low while cke is high");

    // Sampled in the high phase of CLK_48MHZ
    clk_held_before_cke: assert property (@(negedge CLK_48MHZ) disable iff (!RESET)
        sdram_clk |-> cke_seen)
        else $error("sdram_clk toggled before cke was ever raised");

endmodule

bind sdram_interface sdram_checker chk_i (.*);

//--- testbench/sdram_monitor.sv
// Testbench monitor that decodes SDRAM pin commands, compares them with expectations and counts errors
module sdram_monitor (
    input logic                         CLK_48MHZ,
    input logic                         RESET,
    input logic [sdram_pkg::TS_W-1:0]   timestamp,
    input logic                         cke,
    input logic                         cs_n,
    input logic                         ras_n,
    input logic                         cas_n,
    input logic                         we_n,
    input logic [sdram_pkg::BANK_W-1:0] ba,
    input logic [sdram_pkg::ROW_W-1:0]  addr,
    input logic                         dqml,
    input logic                         dqmu,
    input logic                         status
);

    int                                 errors = 0;
    sdram_pkg::sdram_cmd_t              ev_q[$];
    sdram_pkg::sdram_cmd_t              cmd;
    logic                               prev_cke = 1'b0;
    logic                               prev_we_n = 1'b0;
    logic                               init_seen = 1'b0;
    logic [sdram_pkg::BANK_W-1:0]       mrs_ba;
    logic [sdram_pkg::ROW_W-1:0]        mrs_addr;
    logic [sdram_pkg::BANK_W-1:0]       act_ba;
    logic [sdram_pkg::ROW_W-1:0]        act_row;
    logic [sdram_pkg::BANK_W-1:0]       col_ba;
    logic [sdram_pkg::ROW_W-1:0]        col_addr;
    logic                               col_dqml;
    logic                               col_dqmu;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_fail(input string what);
        errors++;
        $display("Failure: %s", what);
    endtask

    task automatic compare_events(input sdram_pkg::sdram_cmd_t exp_q[$]);
        if (ev_q.size() != exp_q.size()) begin
            report_fail($sformatf("saw %0d commands where %0d were expected",
                                  ev_q.size(), exp_q.size()));
        end else begin
            foreach (exp_q[k]) begin
                check_value("command", 32'(ev_q[k]), 32'(exp_q[k]));
            end
        end
        ev_q.delete();
    endtask

    task automatic check_access(input logic is_read, input logic [1:0] bank,
                                input logic [12:0] row, input logic [8:0] col);
        sdram_pkg::sdram_cmd_t exp_q[$];
        exp_q.push_back(sdram_pkg::CMD_SELFX);
        exp_q.push_back(sdram_pkg::CMD_ACTV);
        exp_q.push_back(is_read ? sdram_pkg::CMD_READA : sdram_pkg::CMD_WRITA);
        exp_q.push_back(sdram_pkg::CMD_SELF);
        compare_events(exp_q);
        check_value("ba", 32'(act_ba), 32'(bank));
        check_value("addr", 32'(act_row), 32'(row));
        check_value("ba", 32'(col_ba), 32'(bank));
        // A10 set for auto-precharge
        check_value("addr", 32'(col_addr), 32'({3'b001, 1'b0, col}));
        // Data mask open for the column access
        check_value("dqml", 32'(col_dqml), 32'd0);
        check_value("dqmu", 32'(col_dqmu), 32'd0);
    endtask

    task automatic print_counts();
        $display("Checks finished with %0d errors", errors);
    endtask

    //////////////////////////////////////////////////
    // Command decode at the SDRAM rising edge
    //////////////////////////////////////////////////
    always @(posedge CLK_48MHZ) begin
        sdram_pkg::sdram_cmd_t init_q[$];
        cmd = {cke, cs_n, ras_n, cas_n, we_n};
        if (cmd == sdram_pkg::CMD_SELF) begin
            ev_q.push_back(cmd);
        end else if (cke && !prev_cke && prev_we_n) begin
            // Leaving SELF or the hold NOP
            ev_q.push_back(sdram_pkg::CMD_SELFX);
        end else if (cmd == sdram_pkg::CMD_PALL) begin
            ev_q.push_back(cmd);
        end else if (cmd == sdram_pkg::CMD_MRS) begin
            ev_q.push_back(cmd);
            mrs_ba   = ba;
            mrs_addr = addr;
        end else if (cmd == sdram_pkg::CMD_ACTV) begin
            ev_q.push_back(cmd);
            act_ba  = ba;
            act_row = addr;
        end else if (cmd == sdram_pkg::CMD_READA || cmd == sdram_pkg::CMD_WRITA) begin
            ev_q.push_back(cmd);
            col_ba   = ba;
            col_addr = addr;
            col_dqml = dqml;
            col_dqmu = dqmu;
        end
        prev_cke  = cke;
        prev_we_n = we_n;

        // End of power-up
        if (RESET && !init_seen && !status) begin
            init_seen = 1'b1;
            init_q.push_back(sdram_pkg::CMD_PALL);
            init_q.push_back(sdram_pkg::CMD_SELF);
            init_q.push_back(sdram_pkg::CMD_SELFX);
            init_q.push_back(sdram_pkg::CMD_MRS);
            init_q.push_back(sdram_pkg::CMD_SELF);
            compare_events(init_q);
            check_value("addr", 32'(mrs_addr), 32'(sdram_pkg::MODE_REG));
            check_value("ba", 32'(mrs_ba), 32'(sdram_pkg::MODE_BANK));
            if (timestamp < sdram_pkg::TS_INIT + 24'd1) begin
                report_fail("status fell before the power-up self-refresh had finished");
            end
        end
    end

endmodule

//--- testbench/tb_sdram_interface.sv
// Top-level testbench for the SDRAM controller with a memory model and a table-driven access loop
module tb_sdram_interface;

    typedef struct packed {
        sdram_pkg::host_op_e op;
        logic [1:0]          bank;
        logic [12:0]         row;
        logic [8:0]          col;
        logic                while_busy;
    } stim_t;

    localparam int N_ROWS = 11;

    logic                 CLK_48MHZ = 1'b0;
    logic                 RESET;
    logic [23:0]          timestamp = '0;
    logic [4:0]           ts_div = '0;
    sdram_pkg::host_req_t req;
    logic [15:0]          dq_in = '0;
    logic                 sdram_clk;
    logic                 cke;
    logic                 cs_n;
    logic                 ras_n;
    logic                 cas_n;
    logic                 we_n;
    logic [1:0]           ba;
    logic [12:0]          addr;
    logic                 dqml;
    logic                 dqmu;
    logic [15:0]          dq_out;
    logic                 dq_oe;
    logic                 status;
    logic [15:0]          data_read;

    stim_t                stim [N_ROWS];
    logic [15:0]          shadow [logic [23:0]];
    logic [15:0]          mem [logic [23:0]];
    logic [12:0]          open_row [4];
    logic [23:0]          rd_key;
    int                   rd_wait = 0;
    int                   rd_hold = 0;
    logic [23:0]          lfsr_state = 24'd93448;
    logic                 abort = 1'b0;

    always #2 CLK_48MHZ = ~CLK_48MHZ;

    // Slow time base, one tick per 32 cycles
    always @(posedge CLK_48MHZ) begin
        if (ts_div == 5'd31) begin
            timestamp <= timestamp + 24'd1;
        end
        ts_div <= ts_div + 5'd1;
    end

    sdram_interface dut_i (
        .CLK_48MHZ (CLK_48MHZ),
        .RESET     (RESET),
        .timestamp (timestamp),
        .req       (req),
        .dq_in     (dq_in),
        .sdram_clk (sdram_clk),
        .cke       (cke),
        .cs_n      (cs_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .ba        (ba),
        .addr      (addr),
        .dqml      (dqml),
        .dqmu      (dqmu),
        .dq_out    (dq_out),
        .dq_oe     (dq_oe),
        .status    (status),
        .data_read (data_read)
    );

    sdram_monitor mon_i (
        .CLK_48MHZ (CLK_48MHZ),
        .RESET     (RESET),
        .timestamp (timestamp),
        .cke       (cke),
        .cs_n      (cs_n),
        .ras_n     (ras_n),
        .cas_n     (cas_n),
        .we_n      (we_n),
        .ba        (ba),
        .addr      (addr),
        .dqml      (dqml),
        .dqmu      (dqmu),
        .status    (status)
    );

    //////////////////////////////////////////////////
    // SDRAM memory model
    //////////////////////////////////////////////////
    always @(posedge sdram_clk) begin
        logic [4:0] mcmd;
        mcmd = {cke, cs_n, ras_n, cas_n, we_n};
        if (rd_wait != 0) begin
            rd_wait <= rd_wait - 1;
        end
        if (rd_hold != 0) begin
            rd_hold <= rd_hold - 1;
        end
        if (rd_wait == 1) begin
            dq_in   <= mem.exists(rd_key) ? mem[rd_key] : 16'h0000;
            rd_hold <= 2;
        end else if (rd_hold == 1) begin
            dq_in <= '0;
        end
        if (mcmd == sdram_pkg::CMD_ACTV) begin
            open_row[ba] <= addr;
        end
        if (mcmd == sdram_pkg::CMD_WRITA && dq_oe) begin
            mem[{ba, open_row[ba], addr[8:0]}] = dq_out;
        end
        if (mcmd == sdram_pkg::CMD_READA) begin
            rd_key  <= {ba, open_row[ba], addr[8:0]};
            rd_wait <= sdram_pkg::CAS_LATENCY;
        end
    end

    function automatic logic [23:0] lfsr_step(input logic [23:0] s);
        logic fb;
        // Taps for x^24 + x^23 + x^22 + x^17 + 1
        fb = s[23] ^ s[22] ^ s[21] ^ s[16];
        return {s[22:0], fb};
    endfunction

    function automatic logic [15:0] next_word();
        logic [15:0] w;
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic stim_t make_row(input sdram_pkg::host_op_e op, input logic [1:0] bank,
                                       input logic [12:0] row, input logic [8:0] col,
                                       input logic while_busy);
        stim_t r;
        r.op         = op;
        r.bank       = bank;
        r.row        = row;
        r.col        = col;
        r.while_busy = while_busy;
        return r;
    endfunction

    task automatic wait_status(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (!abort && status !== level && n < limit) begin
            @(posedge CLK_48MHZ);
            n++;
        end
        if (!abort && status !== level) begin
            mon_i.report_fail({"timed out waiting for ", what});
            abort = 1'b1;
        end
    endtask

    task automatic send_req(input stim_t r, input logic [15:0] wdata);
        sdram_pkg::host_req_t q;
        q.op    = r.op;
        q.bank  = r.bank;
        q.row   = r.row;
        q.col   = r.col;
        q.wdata = wdata;
        @(posedge CLK_48MHZ);
        req <= q;
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        logic [23:0] key;
        logic [15:0] wdata;
        logic [15:0] ign_data;
        RESET = 1'b0;
        req   = '0;
        stim[0]  = make_row(sdram_pkg::OP_WRITE, 2'd1, 13'h0123, 9'h045, 1'b0);
        stim[1]  = make_row(sdram_pkg::OP_READ,  2'd1, 13'h0123, 9'h045, 1'b0);
        stim[2]  = make_row(sdram_pkg::OP_WRITE, 2'd1, 13'h0123, 9'h045, 1'b1);
        stim[3]  = make_row(sdram_pkg::OP_READ,  2'd1, 13'h0123, 9'h045, 1'b0);
        stim[4]  = make_row(sdram_pkg::OP_WRITE, 2'd0, 13'h1FFF, 9'h045, 1'b0);
        stim[5]  = make_row(sdram_pkg::OP_WRITE, 2'd3, 13'h0005, 9'h045, 1'b0);
        stim[6]  = make_row(sdram_pkg::OP_WRITE, 2'd2, 13'h1FFF, 9'h045, 1'b0);
        stim[7]  = make_row(sdram_pkg::OP_READ,  2'd0, 13'h1FFF, 9'h045, 1'b0);
        stim[8]  = make_row(sdram_pkg::OP_READ,  2'd3, 13'h0005, 9'h045, 1'b0);
        stim[9]  = make_row(sdram_pkg::OP_READ,  2'd2, 13'h1FFF, 9'h045, 1'b0);
        stim[10] = make_row(sdram_pkg::OP_READ,  2'd1, 13'h0123, 9'h045, 1'b0);

        repeat (8) @(posedge CLK_48MHZ);
        RESET <= 1'b1;
        @(posedge CLK_48MHZ);
        mon_i.check_value("status", 32'(status), 32'd1);
        mon_i.check_value("cke", 32'(cke), 32'd0);
        wait_status(1'b0, 2000, "the end of power-up");

        for (int i = 0; i < N_ROWS; i++) begin
            if (abort) begin
                break;
            end
            if (stim[i].while_busy) begin
                continue;
            end
            key   = {stim[i].bank, stim[i].row, stim[i].col};
            wdata = (stim[i].op == sdram_pkg::OP_WRITE) ? next_word() : 16'h0000;
            wait_status(1'b0, 200, "status low before an access");
            send_req(stim[i], wdata);
            wait_status(1'b1, 20, "the access to be accepted");
            req <= '0;
            // Request held during the access must be dropped
            if (i + 1 < N_ROWS && stim[i + 1].while_busy) begin
                ign_data = next_word();
                send_req(stim[i + 1], ign_data);
                repeat (2) @(posedge CLK_48MHZ);
                req <= '0;
                if (status !== 1'b1) begin
                    mon_i.report_fail("access ended while a request was held during it");
                end
            end
            wait_status(1'b0, 200, "the access to complete");
            if (abort) begin
                break;
            end
            @(negedge CLK_48MHZ);
            mon_i.check_access(stim[i].op == sdram_pkg::OP_READ, stim[i].bank,
                               stim[i].row, stim[i].col);
            if (stim[i].op == sdram_pkg::OP_READ) begin
                mon_i.check_value("data_read", 32'(data_read),
                                  32'(shadow.exists(key) ? shadow[key] : 16'h0000));
            end else begin
                shadow[key] = wdata;
            end
        end

        mon_i.print_counts();
        if (mon_i.errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
